// ==== fpCalc_params.svh ====
`ifndef FPCALC_PARAMS_SVH
`define FPCALC_PARAMS_SVH

// Field widths
`define FP_EXP_W   5
`define FP_MAN_W   12   // Bit 11 is the carry slot, bit 10 the explicit one
`define FP_FRAC_W  10

`define FP_BIAS    15
`define FP_EXP_MAX 31   // All-ones exponent marks an invalid result

// Opcode encoding
`define OP_ADD     2'd0
`define OP_SUB     2'd1
`define OP_MUL     2'd2
`define OP_DIV     2'd3

`endif

// ==== fpCalcPkg.sv ====
`include "fpCalc_params.svh"

package fpCalcPkg;

    // Input operand, 18 bits
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
    } operand_t;

    // Packed result, 16 bits
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } result_t;

    typedef enum logic [1:0] {
        opAdd = `OP_ADD,
        opSub = `OP_SUB,
        opMul = `OP_MUL,
        opDiv = `OP_DIV
    } opcode_t;

    // Unit output before normalization
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
        logic                 invalid;
    } rawResult_t;

    typedef enum logic [2:0] {
        stIdle,
        stWaitB,
        stWaitOp,
        stCompute,
        stEval,
        stSend,
        stDone,
        stError
    } seqState_t;

endpackage

// ==== calcCtrlIf.sv ====
interface calcCtrlIf;

    logic loadA;          // One-cycle load strobes
    logic loadB;
    logic loadOp;
    logic loadResult;
    logic resultInvalid;  // Level, meaningful in the eval state

    modport seq (
        output loadA,
        output loadB,
        output loadOp,
        output loadResult,
        input  resultInvalid
    );

    modport dp (
        input  loadA,
        input  loadB,
        input  loadOp,
        input  loadResult,
        output resultInvalid
    );

endinterface

// ==== addSubUnit.sv ====
`include "fpCalc_params.svh"

module addSubUnit (
    input  fpCalcPkg::operand_t   opA,
    input  fpCalcPkg::operand_t   opB,
    input  logic                  subtract,
    output fpCalcPkg::rawResult_t raw
);

    logic                 signB;
    logic [`FP_EXP_W-1:0] expDiff;
    logic [`FP_EXP_W-1:0] expRes;
    logic [`FP_MAN_W-1:0] manA;
    logic [`FP_MAN_W-1:0] manB;
    logic [`FP_MAN_W-1:0] manRes;
    logic                 signRes;

    assign signB = opB.sign ^ subtract;  // A - B is A + (-B)

    // Align the smaller exponent to the larger one
    always_comb begin
        if (opA.exp >= opB.exp) begin
            expDiff = opA.exp - opB.exp;
            expRes  = opA.exp;
            manA    = opA.man;
            manB    = opB.man >> expDiff;  // Truncating shift
        end else begin
            expDiff = opB.exp - opA.exp;
            expRes  = opB.exp;
            manA    = opA.man >> expDiff;
            manB    = opB.man;
        end
    end

    // Signed-magnitude add
    always_comb begin
        if (opA.sign == signB) begin
            manRes  = manA + manB;  // Carry lands in bit 11
            signRes = opA.sign;
        end else if (manA > manB) begin
            manRes  = manA - manB;
            signRes = opA.sign;
        end else begin
            manRes  = manB - manA;
            signRes = signB;
        end
    end

    assign raw = {signRes, expRes, manRes, 1'b0};  // Never invalid

endmodule

// ==== mulDivUnit.sv ====
`include "fpCalc_params.svh"

module mulDivUnit (
    input  fpCalcPkg::operand_t   opA,
    input  fpCalcPkg::operand_t   opB,
    input  logic                  divide,
    output fpCalcPkg::rawResult_t raw
);

    logic [2*`FP_MAN_W-1:0]         product;
    logic [`FP_MAN_W+`FP_FRAC_W-1:0] dividend;
    logic [`FP_MAN_W+`FP_FRAC_W-1:0] quotient;
    logic [`FP_MAN_W-1:0]           mulMan;
    logic [`FP_MAN_W-1:0]           divMan;
    logic [`FP_EXP_W-1:0]           mulExp;
    logic [`FP_EXP_W-1:0]           divExp;
    logic                           signRes;
    logic                           divInvalid;

    assign signRes = opA.sign ^ opB.sign;

    // Product of two 1.x mantissas has its binary point at bit 20
    assign product = {{`FP_MAN_W{1'b0}}, opA.man} * {{`FP_MAN_W{1'b0}}, opB.man};
    assign mulMan  = product[2*`FP_FRAC_W+1:`FP_FRAC_W];
    assign mulExp  = opA.exp + opB.exp - `FP_EXP_W'(`FP_BIAS);  // Wraps mod 32

    // Dividend pre-scaled so the quotient keeps 10 fraction bits
    assign dividend = {opA.man, {`FP_FRAC_W{1'b0}}};
    assign quotient = (opB.man == '0) ? '0 : dividend / {{`FP_FRAC_W{1'b0}}, opB.man};
    assign divMan   = quotient[`FP_MAN_W-1:0];
    assign divExp   = opA.exp - opB.exp + `FP_EXP_W'(`FP_BIAS);

    // Zero exponent on B counts as divide by zero
    assign divInvalid = (opB.exp == '0) || (divMan == '0);

    assign raw = divide ? {signRes, divExp, divMan, divInvalid}
                        : {signRes, mulExp, mulMan, 1'b0};

endmodule

// ==== normalizer.sv ====
`include "fpCalc_params.svh"

module normalizer (
    input  fpCalcPkg::rawResult_t raw,
    output fpCalcPkg::result_t    packedRes
);

    logic [3:0]           shiftAmt;
    logic [`FP_MAN_W-1:0] manNorm;
    logic [`FP_EXP_W-1:0] expNorm;

    // Leading-one search below the carry bit where the highest set bit wins
    always_comb begin
        shiftAmt = '0;
        for (int i = 0; i < `FP_MAN_W - 1; i++) begin
            if (raw.man[i]) begin
                shiftAmt = 4'(`FP_MAN_W - 2 - i);
            end
        end
    end

    always_comb begin
        if (raw.man[`FP_MAN_W-1]) begin
            manNorm = raw.man >> 1;  // 10.x back to 1.x
            expNorm = raw.exp + `FP_EXP_W'(1);
        end else begin
            manNorm = raw.man << shiftAmt;  // Zero mantissa gives no shift
            expNorm = raw.exp - {1'b0, shiftAmt};
        end
    end

    // Hidden one dropped on packing
    assign packedRes = {raw.sign, expNorm, manNorm[`FP_FRAC_W-1:0]};

endmodule

// ==== opSequencer.sv ====
module opSequencer (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   txReady,
    calcCtrlIf.seq ctrl,
    output logic   txSend,
    output logic   ready,
    output logic   error
);

    fpCalcPkg::seqState_t state;
    fpCalcPkg::seqState_t nextState;

    always_comb begin
        nextState = state;
        case (state)
            fpCalcPkg::stIdle: begin
                if (start) nextState = fpCalcPkg::stWaitB;
            end
            fpCalcPkg::stWaitB: begin
                if (start) nextState = fpCalcPkg::stWaitOp;
            end
            fpCalcPkg::stWaitOp: begin
                if (ctrl.loadOp) nextState = fpCalcPkg::stCompute;  // Opcode lands this edge
            end
            fpCalcPkg::stCompute: nextState = fpCalcPkg::stEval;
            fpCalcPkg::stEval: begin
                if (ctrl.resultInvalid) begin
                    nextState = fpCalcPkg::stError;
                end else begin
                    nextState = fpCalcPkg::stSend;
                end
            end
            fpCalcPkg::stSend: begin
                if (txReady) nextState = fpCalcPkg::stDone;  // Hold until receiver takes it
            end
            fpCalcPkg::stDone:  nextState = fpCalcPkg::stIdle;
            fpCalcPkg::stError: nextState = fpCalcPkg::stIdle;
            default:            nextState = fpCalcPkg::stIdle;
        endcase
    end

    // Strobes and outputs are registered decodes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state           <= fpCalcPkg::stIdle;
            ctrl.loadA      <= 1'b0;
            ctrl.loadB      <= 1'b0;
            ctrl.loadOp     <= 1'b0;
            ctrl.loadResult <= 1'b0;
            txSend          <= 1'b0;
            ready           <= 1'b0;
            error           <= 1'b0;
        end else begin
            state           <= nextState;
            ctrl.loadA      <= start && (state == fpCalcPkg::stIdle);
            ctrl.loadB      <= start && (state == fpCalcPkg::stWaitB);
            // Third strobe is ignored while the opcode load is pending
            ctrl.loadOp     <= start && !ctrl.loadOp && (state == fpCalcPkg::stWaitOp);
            ctrl.loadResult <= (nextState == fpCalcPkg::stCompute);
            txSend          <= (nextState == fpCalcPkg::stSend);
            ready           <= (nextState == fpCalcPkg::stSend) ||
                               (nextState == fpCalcPkg::stDone);
            error           <= (nextState == fpCalcPkg::stError);
        end
    end

    // Delivery follows the datapath verdict which keeps send and error apart
    sendErrorExclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(txSend && ctrl.resultInvalid) && !(error && !ctrl.resultInvalid)
    );

    // Result stays offered until the receiver accepts it
    sendHoldsUntilReady: assert property (
        @(posedge clk) disable iff (!rst) (txSend && !txReady) |=> txSend
    );

endmodule

// ==== fpDatapath.sv ====
`include "fpCalc_params.svh"

module fpDatapath (
    input  logic                 clk,
    input  logic                 rst,
    input  fpCalcPkg::operand_t  a,
    input  fpCalcPkg::operand_t  b,
    input  fpCalcPkg::opcode_t   op,
    calcCtrlIf.dp                ctrl,
    output fpCalcPkg::result_t   result
);

    fpCalcPkg::operand_t   opA;
    fpCalcPkg::operand_t   opB;
    fpCalcPkg::opcode_t    opReg;
    fpCalcPkg::rawResult_t addSubRaw;
    fpCalcPkg::rawResult_t mulDivRaw;
    fpCalcPkg::rawResult_t rawSel;
    fpCalcPkg::result_t    normResult;
    logic                  invalidReg;

    addSubUnit addSub0 (
        .opA      (opA),
        .opB      (opB),
        .subtract (opReg == fpCalcPkg::opSub),
        .raw      (addSubRaw)
    );

    mulDivUnit mulDiv0 (
        .opA    (opA),
        .opB    (opB),
        .divide (opReg == fpCalcPkg::opDiv),
        .raw    (mulDivRaw)
    );

    // Unit select by registered opcode
    assign rawSel = (opReg == fpCalcPkg::opAdd || opReg == fpCalcPkg::opSub) ?
                    addSubRaw : mulDivRaw;

    normalizer norm0 (
        .raw       (rawSel),
        .packedRes (normResult)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            opA        <= '0;
            opB        <= '0;
            opReg      <= fpCalcPkg::opAdd;
            result     <= '0;
            invalidReg <= 1'b0;
        end else begin
            if (ctrl.loadA)  opA   <= a;
            if (ctrl.loadB)  opB   <= b;
            if (ctrl.loadOp) opReg <= op;
            if (ctrl.loadResult) begin
                result     <= normResult;
                // Unit flag or exponent overflow into the all-ones code
                invalidReg <= rawSel.invalid || (normResult.exp == `FP_EXP_MAX);
            end
        end
    end

    assign ctrl.resultInvalid = invalidReg;

    // Sequencer never overlaps result capture with an operand load
    loadsExclusive: assert property (
        @(posedge clk) disable iff (!rst)
        ctrl.loadResult |-> !(ctrl.loadA || ctrl.loadB || ctrl.loadOp)
    );

endmodule

// ==== fpCalcTop.sv ====
module fpCalcTop (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        txReady,
    input  logic [17:0] a,
    input  logic [17:0] b,
    input  logic [1:0]  op,
    output logic [15:0] result,
    output logic        txSend,
    output logic        ready,
    output logic        error
);

    fpCalcPkg::opcode_t opCode;

    calcCtrlIf ctrlBus ();

    assign opCode = fpCalcPkg::opcode_t'(op);

    opSequencer seq0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .txReady (txReady),
        .ctrl    (ctrlBus.seq),
        .txSend  (txSend),
        .ready   (ready),
        .error   (error)
    );

    fpDatapath dp0 (
        .clk    (clk),
        .rst    (rst),
        .a      (a),
        .b      (b),
        .op     (opCode),
        .ctrl   (ctrlBus.dp),
        .result (result)
    );

endmodule

// ==== fpCalcTop_tb.sv ====
`include "fpCalc_params.svh"

module fpCalcTop_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 12;
    localparam int TIMEOUT_NS = NUM_ROWS * 40 * 20;  // 40 cycles of 20 ns per row
    localparam int MAX_WAIT   = 8;                   // Edges allowed for txSend or error

    typedef struct packed {
        logic [17:0] a;
        logic [17:0] b;
        logic [1:0]  op;
        logic [15:0] expResult;
        logic        expError;
    } testRow_t;

    logic        clk;
    logic        rst;
    logic        start;
    logic        txReady;
    logic [17:0] a;
    logic [17:0] b;
    logic [1:0]  op;
    logic [15:0] result;
    logic        txSend;
    logic        ready;
    logic        error;

    logic [31:0] lfsrState;
    testRow_t    vectors [NUM_ROWS];

    fpCalcTop dut0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .txReady (txReady),
        .a       (a),
        .b       (b),
        .op      (op),
        .result  (result),
        .txSend  (txSend),
        .ready   (ready),
        .error   (error)
    );

    always #10 clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawBits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value     = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Error: %s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic loadVectors();
        // a, b, opcode, expected result, expected error
        vectors[0]  = '{18'h0F400, 18'h0F400, `OP_ADD, 16'h4000, 1'b0};  // 1 + 1 with carry
        vectors[1]  = '{18'h0F600, 18'h0D500, `OP_ADD, 16'h3F40, 1'b0};  // 1.5 + 0.3125
        vectors[2]  = '{18'h10400, 18'h2E400, `OP_ADD, 16'h3E00, 1'b0};  // 2 + -0.5
        vectors[3]  = '{18'h0F400, 18'h10600, `OP_SUB, 16'hC000, 1'b0};  // 1 - 3
        vectors[4]  = '{18'h0F408, 18'h0F400, `OP_SUB, 16'h2000, 1'b0};  // Seven left shifts
        vectors[5]  = '{18'h2F600, 18'h2F600, `OP_ADD, 16'hC200, 1'b0};  // -1.5 + -1.5
        vectors[6]  = '{18'h0F600, 18'h10500, `OP_MUL, 16'h4380, 1'b0};  // 1.5 * 2.5
        vectors[7]  = '{18'h2F600, 18'h0F600, `OP_MUL, 16'hC080, 1'b0};  // -1.5 * 1.5
        vectors[8]  = '{18'h30600, 18'h0F600, `OP_DIV, 16'hC000, 1'b0};  // -3 / 1.5
        vectors[9]  = '{18'h0F400, 18'h2F600, `OP_DIV, 16'hB954, 1'b0};  // 1 / -1.5
        vectors[10] = '{18'h0F400, 18'h00400, `OP_DIV, 16'h7800, 1'b1};  // B exponent zero
        vectors[11] = '{18'h16600, 18'h17600, `OP_MUL, 16'h7C80, 1'b1};  // Exponent hits 31
    endtask

    // One-cycle start pulse that returns on the edge sampling it
    task automatic pulseStart(input int gap);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic runRow(input int idx);
        testRow_t row;
        int       edgesWaited;
        int       lowCycles;
        row = vectors[idx];
        @(posedge clk);
        a  <= row.a;
        b  <= row.b;
        op <= row.op;
        pulseStart(2);
        pulseStart(2);
        pulseStart(0);

        edgesWaited = 0;
        do begin
            @(posedge clk);
            edgesWaited++;
            @(negedge clk);
        end while (!(txSend || error) && edgesWaited < MAX_WAIT);

        if (!(txSend || error)) begin
            abortRun($sformatf("row %0d: neither txSend nor error rose", idx));
        end
        if (edgesWaited != 3) begin
            abortRun($sformatf("row %0d: output rose %0d edges after the third start",
                               idx, edgesWaited));
        end
        checkValue("result", 32'(result), 32'(row.expResult));
        checkValue("error", 32'(error), 32'(row.expError));

        if (row.expError) begin
            checkValue("txSend", 32'(txSend), 0);
            checkValue("ready", 32'(ready), 0);
            @(posedge clk);
            @(negedge clk);
            checkValue("error", 32'(error), 0);  // Single-cycle pulse
            checkValue("txSend", 32'(txSend), 0);
        end else begin
            checkValue("txSend", 32'(txSend), 1);
            checkValue("ready", 32'(ready), 1);
            drawBits(3, lowCycles);
            repeat (lowCycles) begin
                @(posedge clk);
                @(negedge clk);
                checkValue("txSend", 32'(txSend), 1);  // Held under back-pressure
                checkValue("ready", 32'(ready), 1);
                checkValue("error", 32'(error), 0);
                checkValue("result", 32'(result), 32'(row.expResult));
            end
            @(posedge clk);
            txReady <= 1'b1;
            @(negedge clk);
            checkValue("txSend", 32'(txSend), 1);
            @(posedge clk);
            txReady <= 1'b0;
            @(negedge clk);
            checkValue("txSend", 32'(txSend), 0);
            checkValue("ready", 32'(ready), 1);  // Done state
            checkValue("result", 32'(result), 32'(row.expResult));
            @(posedge clk);
            @(negedge clk);
            checkValue("ready", 32'(ready), 0);
        end
    endtask

    initial begin
        int idx;
        clk       = 1'b0;
        rst       = 1'b0;
        start     = 1'b0;
        txReady   = 1'b0;
        a         = '0;
        b         = '0;
        op        = '0;
        lfsrState = 32'he1fb;
        loadVectors();

        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkValue("txSend", 32'(txSend), 0);
        checkValue("ready", 32'(ready), 0);
        checkValue("error", 32'(error), 0);
        checkValue("result", 32'(result), 0);

        for (idx = 0; idx < NUM_ROWS; idx++) begin
            runRow(idx);
        end

        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        abortRun("watchdog expired before all rows completed");
    end

endmodule

// ==== fpCalcTop.f ====
+incdir+.
fpCalcPkg.sv
calcCtrlIf.sv
addSubUnit.sv
mulDivUnit.sv
normalizer.sv
opSequencer.sv
fpDatapath.sv
fpCalcTop.sv
fpCalcTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fpCalcTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fpCalcTop_tb -f fpCalcTop.f -o simFpCalc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simFpCalc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
